// ==== rtl/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define RESET_PC   32'h0000_0000
`define REG_NUM    32

`define OP_SPECIAL 6'b000000
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDIU   6'b001001
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

`define FN_ADDU    6'b100001
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_SLT     6'b101010

`endif

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

// data word on registers, buses and ALU operands
typedef logic [31:0] uint32_t;

// instruction or data address
typedef logic [31:0] virt_t;

typedef logic [4:0] reg_addr_t;

// instruction word fields
typedef logic [5:0] opcode_t;
typedef logic [5:0] funct_t;

typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI,
	ALU_PASS_B
} alu_op_t;

endpackage

// ==== rtl/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instr_fetch(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stall,
	input  logic             redirect,
	input  cpu_pkg::virt_t   redirect_pc,
	output logic             ibus_read,
	output cpu_pkg::virt_t   ibus_address,
	input  cpu_pkg::uint32_t ibus_rddata,
	input  logic             ibus_stall,
	output logic             stall_req,
	output cpu_pkg::uint32_t instr,
	output cpu_pkg::virt_t   pc,
	output logic             valid
);

cpu_pkg::virt_t pc_q;
cpu_pkg::virt_t pending_pc_q;
cpu_pkg::virt_t target_pc;
logic           pending_q;
logic           take_target;

// a fetch is always in flight
assign ibus_read    = 1'b1;
assign ibus_address = pc_q;
assign stall_req    = ibus_stall;

assign instr = ibus_rddata;
assign pc    = pc_q;
// word fetched on the old path is dropped
assign valid = ~ibus_stall & ~pending_q;

assign take_target = redirect | pending_q;
assign target_pc   = redirect ? redirect_pc : pending_pc_q;

always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		pc_q      <= `RESET_PC;
		pending_q <= 1'b0;
	end else if (ibus_stall) begin
		// address must stay put, remember the target
		if (redirect) begin
			pending_q <= 1'b1;
		end
	end else if (take_target) begin
		pc_q      <= target_pc;
		pending_q <= 1'b0;
	end else if (~stall) begin
		pc_q <= pc_q + 32'd4;
	end
end

always_ff @(posedge clk) begin
	if (ibus_stall && redirect) begin
		pending_pc_q <= redirect_pc;
	end
end

endmodule

// ==== rtl/decode_issue.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_issue(
	input  cpu_pkg::uint32_t   instr,
	input  cpu_pkg::virt_t     pc,
	input  logic               valid,
	output cpu_pkg::reg_addr_t reg_raddr_a,
	output cpu_pkg::reg_addr_t reg_raddr_b,
	input  cpu_pkg::uint32_t   reg_rdata_a,
	input  cpu_pkg::uint32_t   reg_rdata_b,
	input  cpu_pkg::reg_addr_t ex_rd,
	input  cpu_pkg::reg_addr_t mem_rd,
	input  cpu_pkg::uint32_t   ex_result,
	input  cpu_pkg::uint32_t   mem_result,
	input  logic               ex_is_load,
	output cpu_pkg::alu_op_t   alu_op,
	output cpu_pkg::uint32_t   op_a,
	output cpu_pkg::uint32_t   op_b,
	output cpu_pkg::uint32_t   store_data,
	output cpu_pkg::uint32_t   branch_target,
	output logic               is_branch,
	output logic               branch_ne,
	output logic               is_load,
	output logic               is_store,
	output cpu_pkg::reg_addr_t rd,
	output logic               stall_req
);

cpu_pkg::opcode_t   opcode;
cpu_pkg::funct_t    funct;
cpu_pkg::reg_addr_t rs;
cpu_pkg::reg_addr_t rt;
cpu_pkg::reg_addr_t rd_field;
cpu_pkg::uint32_t   imm_sext;
cpu_pkg::uint32_t   imm_zext;
cpu_pkg::uint32_t   rs_value;
cpu_pkg::uint32_t   rt_value;
logic               use_rs;
logic               use_rt;

function automatic cpu_pkg::uint32_t fwd_value(
	input cpu_pkg::reg_addr_t src,
	input cpu_pkg::uint32_t   rf_value,
	input cpu_pkg::reg_addr_t ex_dst,
	input cpu_pkg::uint32_t   ex_value,
	input cpu_pkg::reg_addr_t mem_dst,
	input cpu_pkg::uint32_t   mem_value
);
	if (src == '0) begin
		return '0;
	end else if (src == ex_dst) begin
		return ex_value;
	end else if (src == mem_dst) begin
		return mem_value;
	end
	return rf_value;
endfunction

assign opcode   = instr[31:26];
assign rs       = instr[25:21];
assign rt       = instr[20:16];
assign rd_field = instr[15:11];
assign funct    = instr[5:0];
assign imm_sext = {{16{instr[15]}}, instr[15:0]};
assign imm_zext = {16'h0000, instr[15:0]};

assign reg_raddr_a = rs;
assign reg_raddr_b = rt;

assign rs_value = fwd_value(rs, reg_rdata_a, ex_rd, ex_result, mem_rd, mem_result);
assign rt_value = fwd_value(rt, reg_rdata_b, ex_rd, ex_result, mem_rd, mem_result);

always_comb begin
	alu_op        = cpu_pkg::ALU_PASS_B;
	op_a          = rs_value;
	op_b          = rt_value;
	store_data    = rt_value;
	branch_target = pc + 32'd4 + {imm_sext[29:0], 2'b00};
	is_branch     = 1'b0;
	branch_ne     = 1'b0;
	is_load       = 1'b0;
	is_store      = 1'b0;
	rd            = '0;
	use_rs        = 1'b0;
	use_rt        = 1'b0;
	if (valid) begin
		case (opcode)
		`OP_SPECIAL: begin
			use_rs = 1'b1;
			use_rt = 1'b1;
			rd     = rd_field;
			case (funct)
			`FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
			`FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
			`FN_AND:  alu_op = cpu_pkg::ALU_AND;
			`FN_OR:   alu_op = cpu_pkg::ALU_OR;
			`FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
			`FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
			default:  rd = '0;
			endcase
		end
		`OP_ADDIU, `OP_LW, `OP_SW: begin
			use_rs   = 1'b1;
			use_rt   = (opcode == `OP_SW);
			alu_op   = cpu_pkg::ALU_ADD;
			op_b     = imm_sext;
			is_load  = (opcode == `OP_LW);
			is_store = (opcode == `OP_SW);
			rd       = (opcode == `OP_SW) ? '0 : rt;
		end
		`OP_ORI: begin
			use_rs = 1'b1;
			alu_op = cpu_pkg::ALU_OR;
			op_b   = imm_zext;
			rd     = rt;
		end
		`OP_LUI: begin
			alu_op = cpu_pkg::ALU_LUI;
			op_b   = imm_zext;
			rd     = rt;
		end
		`OP_BEQ, `OP_BNE: begin
			use_rs    = 1'b1;
			use_rt    = 1'b1;
			is_branch = 1'b1;
			branch_ne = (opcode == `OP_BNE);
		end
		default: begin
			// unknown opcode runs as nop
			rd = '0;
		end
		endcase
	end
end

// load result not ready until MEM
assign stall_req = ex_is_load && (ex_rd != '0) &&
	((use_rs && rs == ex_rd) || (use_rt && rt == ex_rd));

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regfile(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::uint32_t   wdata,
	input  cpu_pkg::reg_addr_t raddr_a,
	input  cpu_pkg::reg_addr_t raddr_b,
	output cpu_pkg::uint32_t   rdata_a,
	output cpu_pkg::uint32_t   rdata_b
);

cpu_pkg::uint32_t regs [`REG_NUM];
logic             wr_en;

// r0 stays zero
assign wr_en = we && (waddr != '0);

always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		for (int i = 0; i < `REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (wr_en) begin
		regs[waddr] <= wdata;
	end
end

// write-through bypass
assign rdata_a = (wr_en && waddr == raddr_a) ? wdata : regs[raddr_a];
assign rdata_b = (wr_en && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// ==== rtl/instr_exec.sv ====
`timescale 1ns/1ps

module instr_exec(
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::uint32_t op_a,
	input  cpu_pkg::uint32_t op_b,
	input  cpu_pkg::uint32_t store_data,
	input  cpu_pkg::uint32_t branch_target,
	input  logic             is_branch,
	input  logic             branch_ne,
	output cpu_pkg::uint32_t result,
	output logic             redirect,
	output cpu_pkg::virt_t   redirect_pc
);

logic regs_equal;

always_comb begin
	case (alu_op)
	cpu_pkg::ALU_ADD: begin
		result = op_a + op_b;
	end
	cpu_pkg::ALU_SUB: begin
		result = op_a - op_b;
	end
	cpu_pkg::ALU_AND: begin
		result = op_a & op_b;
	end
	cpu_pkg::ALU_OR: begin
		result = op_a | op_b;
	end
	cpu_pkg::ALU_XOR: begin
		result = op_a ^ op_b;
	end
	cpu_pkg::ALU_SLT: begin
		result = {31'd0, $signed(op_a) < $signed(op_b)};
	end
	cpu_pkg::ALU_LUI: begin
		result = {op_b[15:0], 16'h0000};
	end
	default: begin
		result = op_b;
	end
	endcase
end

// rt value rides on store_data for every instruction
assign regs_equal = (op_a == store_data);

assign redirect    = is_branch && (branch_ne ? ~regs_equal : regs_equal);
assign redirect_pc = branch_target;

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem(
	input  logic             is_load,
	input  logic             is_store,
	input  cpu_pkg::uint32_t result,
	input  cpu_pkg::uint32_t store_data,
	output logic             dbus_read,
	output logic             dbus_write,
	output cpu_pkg::virt_t   dbus_address,
	output cpu_pkg::uint32_t dbus_wdata,
	input  cpu_pkg::uint32_t dbus_rddata,
	input  logic             dbus_stall,
	output logic             stall_req,
	output cpu_pkg::uint32_t wb_data
);

logic access;

assign access = is_load | is_store;

assign dbus_read    = is_load;
assign dbus_write   = is_store;
// ALU add result is the address
assign dbus_address = result;
assign dbus_wdata   = store_data;

// stall only matters while a request is out
assign stall_req = access & dbus_stall;

assign wb_data = is_load ? dbus_rddata : result;

endmodule

// ==== rtl/ctrl.sv ====
`timescale 1ns/1ps

module ctrl(
	input  logic stall_from_if,
	input  logic stall_from_id,
	input  logic stall_from_mm,
	input  logic redirect,
	output logic stall_if,
	output logic stall_id,
	output logic stall_ex,
	output logic flush_id,
	output logic flush_ex,
	output logic flush_mm,
	output logic redirect_ok
);

logic branch_taken;

// each stall freezes its own stage and all older ones
assign stall_ex = stall_from_mm;
assign stall_id = stall_from_mm | stall_from_id;
assign stall_if = stall_from_mm | stall_from_id | stall_from_if;

// a branch in a frozen EX waits
assign redirect_ok  = ~stall_ex;
assign branch_taken = redirect & redirect_ok;

// bubble goes into the register right after the last frozen stage
assign flush_id = branch_taken | (stall_if & ~stall_id);
assign flush_ex = branch_taken | (stall_id & ~stall_ex);
assign flush_mm = stall_from_mm;

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core(
	input  logic             clk,
	input  logic             rst_n,
	output logic             ibus_read,
	output cpu_pkg::virt_t   ibus_address,
	input  cpu_pkg::uint32_t ibus_rddata,
	input  logic             ibus_stall,
	output logic             dbus_read,
	output logic             dbus_write,
	output cpu_pkg::virt_t   dbus_address,
	output cpu_pkg::uint32_t dbus_wdata,
	input  cpu_pkg::uint32_t dbus_rddata,
	input  logic             dbus_stall
);

logic stall_if, stall_id, stall_ex;
logic flush_id, flush_ex, flush_mm;
logic stall_from_if, stall_from_id, stall_from_mm;
logic redirect_ok;

cpu_pkg::uint32_t if_instr;
cpu_pkg::virt_t   if_pc;
logic             if_valid;

cpu_pkg::uint32_t ifid_instr;
cpu_pkg::virt_t   ifid_pc;
logic             ifid_valid;

cpu_pkg::alu_op_t   id_alu_op;
cpu_pkg::uint32_t   id_op_a, id_op_b, id_store_data, id_branch_target;
logic               id_is_branch, id_branch_ne, id_is_load, id_is_store;
cpu_pkg::reg_addr_t id_rd;

cpu_pkg::alu_op_t   idex_alu_op;
cpu_pkg::uint32_t   idex_op_a, idex_op_b, idex_store_data, idex_branch_target;
logic               idex_is_branch, idex_branch_ne, idex_is_load, idex_is_store;
cpu_pkg::reg_addr_t idex_rd;

cpu_pkg::uint32_t ex_result;
logic             ex_redirect;
cpu_pkg::virt_t   ex_redirect_pc;
logic             fetch_redirect;

cpu_pkg::uint32_t   exmem_result, exmem_store_data;
logic               exmem_is_load, exmem_is_store;
cpu_pkg::reg_addr_t exmem_rd;
cpu_pkg::uint32_t   mem_wb_data;

cpu_pkg::reg_addr_t memwb_rd;
cpu_pkg::uint32_t   memwb_wdata;

cpu_pkg::reg_addr_t reg_raddr_a, reg_raddr_b;
cpu_pkg::uint32_t   reg_rdata_a, reg_rdata_b;

assign fetch_redirect = ex_redirect & redirect_ok;

ctrl ctrl_i(
	.stall_from_if ( stall_from_if ),
	.stall_from_id ( stall_from_id ),
	.stall_from_mm ( stall_from_mm ),
	.redirect      ( ex_redirect   ),
	.stall_if      ( stall_if      ),
	.stall_id      ( stall_id      ),
	.stall_ex      ( stall_ex      ),
	.flush_id      ( flush_id      ),
	.flush_ex      ( flush_ex      ),
	.flush_mm      ( flush_mm      ),
	.redirect_ok   ( redirect_ok   )
);

instr_fetch fetch_i(
	.clk,
	.rst_n,
	.stall        ( stall_if       ),
	.redirect     ( fetch_redirect ),
	.redirect_pc  ( ex_redirect_pc ),
	.ibus_read,
	.ibus_address,
	.ibus_rddata,
	.ibus_stall,
	.stall_req    ( stall_from_if  ),
	.instr        ( if_instr       ),
	.pc           ( if_pc          ),
	.valid        ( if_valid       )
);

// IF/ID
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		ifid_valid <= 1'b0;
	end else if (flush_id) begin
		ifid_valid <= 1'b0;
	end else if (~stall_id) begin
		ifid_valid <= if_valid;
	end
end

always_ff @(posedge clk) begin
	if (~stall_id) begin
		ifid_instr <= if_instr;
		ifid_pc    <= if_pc;
	end
end

regfile regfile_i(
	.clk,
	.rst_n,
	.we      ( memwb_rd != '0 ),
	.waddr   ( memwb_rd       ),
	.wdata   ( memwb_wdata    ),
	.raddr_a ( reg_raddr_a    ),
	.raddr_b ( reg_raddr_b    ),
	.rdata_a ( reg_rdata_a    ),
	.rdata_b ( reg_rdata_b    )
);

decode_issue decode_i(
	.instr         ( ifid_instr       ),
	.pc            ( ifid_pc          ),
	.valid         ( ifid_valid       ),
	.reg_raddr_a,
	.reg_raddr_b,
	.reg_rdata_a,
	.reg_rdata_b,
	.ex_rd         ( idex_rd          ),
	.mem_rd        ( exmem_rd         ),
	.ex_result     ( ex_result        ),
	.mem_result    ( mem_wb_data      ),
	.ex_is_load    ( idex_is_load     ),
	.alu_op        ( id_alu_op        ),
	.op_a          ( id_op_a          ),
	.op_b          ( id_op_b          ),
	.store_data    ( id_store_data    ),
	.branch_target ( id_branch_target ),
	.is_branch     ( id_is_branch     ),
	.branch_ne     ( id_branch_ne     ),
	.is_load       ( id_is_load       ),
	.is_store      ( id_is_store      ),
	.rd            ( id_rd            ),
	.stall_req     ( stall_from_id    )
);

// a bubble in ID/EX only clears the fields that act
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		idex_is_branch <= 1'b0;
		idex_is_load   <= 1'b0;
		idex_is_store  <= 1'b0;
		idex_rd        <= '0;
	end else if (flush_ex) begin
		idex_is_branch <= 1'b0;
		idex_is_load   <= 1'b0;
		idex_is_store  <= 1'b0;
		idex_rd        <= '0;
	end else if (~stall_ex) begin
		idex_is_branch <= id_is_branch;
		idex_is_load   <= id_is_load;
		idex_is_store  <= id_is_store;
		idex_rd        <= id_rd;
	end
end

always_ff @(posedge clk) begin
	if (~stall_ex) begin
		idex_alu_op        <= id_alu_op;
		idex_op_a          <= id_op_a;
		idex_op_b          <= id_op_b;
		idex_store_data    <= id_store_data;
		idex_branch_target <= id_branch_target;
		idex_branch_ne     <= id_branch_ne;
	end
end

instr_exec exec_i(
	.alu_op        ( idex_alu_op        ),
	.op_a          ( idex_op_a          ),
	.op_b          ( idex_op_b          ),
	.store_data    ( idex_store_data    ),
	.branch_target ( idex_branch_target ),
	.is_branch     ( idex_is_branch     ),
	.branch_ne     ( idex_branch_ne     ),
	.result        ( ex_result          ),
	.redirect      ( ex_redirect        ),
	.redirect_pc   ( ex_redirect_pc     )
);

// EX/MEM holds while the data bus stalls
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		exmem_is_load  <= 1'b0;
		exmem_is_store <= 1'b0;
		exmem_rd       <= '0;
	end else if (~stall_ex) begin
		exmem_is_load  <= idex_is_load;
		exmem_is_store <= idex_is_store;
		exmem_rd       <= idex_rd;
	end
end

always_ff @(posedge clk) begin
	if (~stall_ex) begin
		exmem_result     <= ex_result;
		exmem_store_data <= idex_store_data;
	end
end

instr_mem mem_i(
	.is_load      ( exmem_is_load    ),
	.is_store     ( exmem_is_store   ),
	.result       ( exmem_result     ),
	.store_data   ( exmem_store_data ),
	.dbus_read,
	.dbus_write,
	.dbus_address,
	.dbus_wdata,
	.dbus_rddata,
	.dbus_stall,
	.stall_req    ( stall_from_mm    ),
	.wb_data      ( mem_wb_data      )
);

// MEM/WB
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		memwb_rd <= '0;
	end else if (flush_mm) begin
		memwb_rd <= '0;
	end else begin
		memwb_rd <= exmem_rd;
	end
end

always_ff @(posedge clk) begin
	memwb_wdata <= mem_wb_data;
end

endmodule

// ==== tests/cpu_core_chk.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core_chk(
	input logic             clk,
	input logic             rst_n,
	input logic             ibus_read,
	input cpu_pkg::virt_t   ibus_address,
	input logic             ibus_stall,
	input logic             dbus_read,
	input logic             dbus_write,
	input cpu_pkg::virt_t   dbus_address,
	input cpu_pkg::uint32_t dbus_wdata,
	input logic             dbus_stall
);

a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
	!(dbus_read && dbus_write))
	else $error("data bus read and write high together");

// a stalled request must not move
a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
	(ibus_read && ibus_stall) |=> (ibus_read && $stable(ibus_address)))
	else $error("instruction bus request changed during a stall");

a_dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
	((dbus_read || dbus_write) && dbus_stall) |=>
	($stable(dbus_read) && $stable(dbus_write) &&
	$stable(dbus_address) && $stable(dbus_wdata)))
	else $error("data bus request changed during a stall");

// first cycle out of reset
a_reset_state: assert property (@(posedge clk)
	$rose(rst_n) |-> (ibus_read && ibus_address == `RESET_PC &&
	!dbus_read && !dbus_write))
	else $error("bus state wrong in the first cycle after reset");

endmodule

bind cpu_core cpu_core_chk chk_i(
	.clk          ( clk          ),
	.rst_n        ( rst_n        ),
	.ibus_read    ( ibus_read    ),
	.ibus_address ( ibus_address ),
	.ibus_stall   ( ibus_stall   ),
	.dbus_read    ( dbus_read    ),
	.dbus_write   ( dbus_write   ),
	.dbus_address ( dbus_address ),
	.dbus_wdata   ( dbus_wdata   ),
	.dbus_stall   ( dbus_stall   )
);

// ==== tests/cpu_core_tb.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core_tb;

localparam int PROG_LEN    = 200;
localparam int MAX_CYCLES  = 20000;
localparam int END_FETCHES = 20;

logic             clk;
logic             rst_n;
logic             ibus_read;
cpu_pkg::virt_t   ibus_address;
cpu_pkg::uint32_t ibus_rddata;
logic             ibus_stall;
logic             dbus_read;
logic             dbus_write;
cpu_pkg::virt_t   dbus_address;
cpu_pkg::uint32_t dbus_wdata;
cpu_pkg::uint32_t dbus_rddata;
logic             dbus_stall;

cpu_pkg::uint32_t prog [256];
cpu_pkg::uint32_t dmem [64];
cpu_pkg::uint32_t iss_regs [32];
cpu_pkg::uint32_t iss_mem [64];
cpu_pkg::virt_t   exp_st_addr [$];
cpu_pkg::uint32_t exp_st_data [$];
cpu_pkg::virt_t   exp_ld_addr [$];

logic [31:0]      seed;
int               errors;
int               st_idx;
int               ld_idx;
int               end_fetches;
int               cycles;
logic             first_cycle;
logic             prev_i_wait;
logic             prev_d_wait;
logic             prev_d_read;
logic             prev_d_write;
cpu_pkg::virt_t   prev_iaddr;
cpu_pkg::virt_t   prev_daddr;
cpu_pkg::uint32_t prev_wdata;

cpu_core dut_i(
	.clk          ( clk          ),
	.rst_n        ( rst_n        ),
	.ibus_read    ( ibus_read    ),
	.ibus_address ( ibus_address ),
	.ibus_rddata  ( ibus_rddata  ),
	.ibus_stall   ( ibus_stall   ),
	.dbus_read    ( dbus_read    ),
	.dbus_write   ( dbus_write   ),
	.dbus_address ( dbus_address ),
	.dbus_wdata   ( dbus_wdata   ),
	.dbus_rddata  ( dbus_rddata  ),
	.dbus_stall   ( dbus_stall   )
);

always #2 clk = ~clk;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic logic [15:0] next_rand();
	seed = lcg_next(seed);
	return seed[31:16];
endfunction

// every address bit feeds the pattern
function automatic cpu_pkg::uint32_t fill_word(input int idx);
	return (cpu_pkg::uint32_t'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
endfunction

function automatic logic [5:0] funct_for(input int kind);
	case (kind)
	0: return `FN_ADDU;
	1: return `FN_SUBU;
	2: return `FN_AND;
	3: return `FN_OR;
	4: return `FN_XOR;
	default: return `FN_SLT;
	endcase
endfunction

task automatic gen_program();
	logic [15:0] r;
	logic [15:0] imm;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	int          kind;
	int          lim;
	for (int i = 0; i < 256; i++) begin
		prog[i] = '0;
	end
	for (int i = 0; i < PROG_LEN; i++) begin
		r    = next_rand();
		kind = int'(r[3:0]);
		// few registers so hazards are common
		rs   = {2'b00, r[6:4]};
		rt   = {2'b00, r[9:7]};
		rd   = {2'b00, r[12:10]};
		imm  = next_rand();
		lim  = PROG_LEN - 1 - i;
		if ((kind == 13 || kind == 14) && lim < 1) begin
			kind = 7;
		end
		case (kind)
		0, 1, 2, 3, 4, 5: prog[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, funct_for(kind)};
		6:       prog[i] = {`OP_ADDIU, rs, rt, imm};
		7:       prog[i] = {`OP_ORI, rs, rt, imm};
		8:       prog[i] = {`OP_LUI, 5'd0, rt, imm};
		9, 10:   prog[i] = {`OP_LW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
		11, 12:  prog[i] = {`OP_SW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
		13, 14: begin
			imm = 16'(1 + int'(imm) % (lim < 3 ? lim : 3));
			prog[i] = {(kind == 13) ? `OP_BEQ : `OP_BNE, rs, rt, imm};
		end
		default: prog[i] = {6'h3F, rs, rt, imm};
		endcase
	end
	// branch to self ends the program
	prog[PROG_LEN] = {`OP_BEQ, 5'd0, 5'd0, 16'hFFFF};
endtask

task automatic run_iss();
	cpu_pkg::uint32_t ins;
	cpu_pkg::uint32_t a;
	cpu_pkg::uint32_t b;
	cpu_pkg::uint32_t sext;
	cpu_pkg::uint32_t addr;
	logic [4:0]       rt;
	logic [4:0]       rd;
	int               pc;
	int               steps;
	for (int i = 0; i < 32; i++) begin
		iss_regs[i] = '0;
	end
	for (int i = 0; i < 64; i++) begin
		iss_mem[i] = fill_word(i);
	end
	pc    = 0;
	steps = 0;
	while (pc != PROG_LEN && steps < 1000) begin
		ins   = prog[pc];
		a     = iss_regs[ins[25:21]];
		b     = iss_regs[ins[20:16]];
		rt    = ins[20:16];
		rd    = ins[15:11];
		sext  = {{16{ins[15]}}, ins[15:0]};
		addr  = a + sext;
		pc    = pc + 1;
		steps = steps + 1;
		case (ins[31:26])
		`OP_SPECIAL: begin
			case (ins[5:0])
			`FN_ADDU: iss_regs[rd] = a + b;
			`FN_SUBU: iss_regs[rd] = a - b;
			`FN_AND:  iss_regs[rd] = a & b;
			`FN_OR:   iss_regs[rd] = a | b;
			`FN_XOR:  iss_regs[rd] = a ^ b;
			`FN_SLT:  iss_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: ;
			endcase
		end
		`OP_ADDIU: iss_regs[rt] = a + sext;
		`OP_ORI:   iss_regs[rt] = a | {16'h0000, ins[15:0]};
		`OP_LUI:   iss_regs[rt] = {ins[15:0], 16'h0000};
		`OP_LW: begin
			iss_regs[rt] = iss_mem[addr[7:2]];
			exp_ld_addr.push_back(addr);
		end
		`OP_SW: begin
			iss_mem[addr[7:2]] = b;
			exp_st_addr.push_back(addr);
			exp_st_data.push_back(b);
		end
		`OP_BEQ: if (a == b) pc = pc + int'($signed(ins[15:0]));
		`OP_BNE: if (a != b) pc = pc + int'($signed(ins[15:0]));
		default: ;
		endcase
		iss_regs[0] = '0;
	end
endtask

task automatic drive_inputs();
	logic [15:0] r;
	r           = next_rand();
	ibus_stall  = (r[1:0] == 2'd0);
	dbus_stall  = (r[9:8] == 2'd0);
	ibus_rddata = prog[ibus_address[9:2]];
	dbus_rddata = dmem[dbus_address[7:2]];
endtask

task automatic check_store();
	assert (st_idx < exp_st_addr.size()) else begin
		errors++;
		$display("unexpected store at %0d ns to address %h", $time, dbus_address);
	end
	if (st_idx < exp_st_addr.size()) begin
		assert (dbus_address == exp_st_addr[st_idx]) else begin
			errors++;
			$display("mismatch at %0d ns: dbus_address = %h, expected %h",
				$time, dbus_address, exp_st_addr[st_idx]);
		end
		assert (dbus_wdata == exp_st_data[st_idx]) else begin
			errors++;
			$display("mismatch at %0d ns: dbus_wdata = %h, expected %h",
				$time, dbus_wdata, exp_st_data[st_idx]);
		end
	end
	st_idx++;
	dmem[dbus_address[7:2]] = dbus_wdata;
endtask

task automatic check_load();
	assert (ld_idx < exp_ld_addr.size()) else begin
		errors++;
		$display("unexpected load at %0d ns from address %h", $time, dbus_address);
	end
	if (ld_idx < exp_ld_addr.size()) begin
		assert (dbus_address == exp_ld_addr[ld_idx]) else begin
			errors++;
			$display("mismatch at %0d ns: dbus_address = %h, expected %h",
				$time, dbus_address, exp_ld_addr[ld_idx]);
		end
	end
	ld_idx++;
endtask

task automatic monitor_cycle();
	if (first_cycle) begin
		assert (ibus_read) else begin
			errors++;
			$display("mismatch at %0d ns: ibus_read = %b, expected 1", $time, ibus_read);
		end
		assert (!dbus_read) else begin
			errors++;
			$display("mismatch at %0d ns: dbus_read = %b, expected 0", $time, dbus_read);
		end
		assert (!dbus_write) else begin
			errors++;
			$display("mismatch at %0d ns: dbus_write = %b, expected 0", $time, dbus_write);
		end
		assert (ibus_address == `RESET_PC) else begin
			errors++;
			$display("mismatch at %0d ns: ibus_address = %h, expected %h",
				$time, ibus_address, `RESET_PC);
		end
		first_cycle = 1'b0;
	end
	assert (!(dbus_read && dbus_write)) else begin
		errors++;
		$display("data bus read and write both high at %0d ns", $time);
	end
	assert (!prev_i_wait || (ibus_read && ibus_address == prev_iaddr)) else begin
		errors++;
		$display("instruction request changed during a stall at %0d ns", $time);
	end
	assert (!prev_d_wait || (dbus_read == prev_d_read && dbus_write == prev_d_write &&
		dbus_address == prev_daddr && dbus_wdata == prev_wdata)) else begin
		errors++;
		$display("data request changed during a stall at %0d ns", $time);
	end
	if (ibus_read && !ibus_stall && ibus_address == cpu_pkg::virt_t'(PROG_LEN * 4)) begin
		end_fetches++;
	end
	if (dbus_write && !dbus_stall) begin
		check_store();
	end
	if (dbus_read && !dbus_stall) begin
		check_load();
	end
	prev_i_wait  = ibus_read && ibus_stall;
	prev_d_wait  = (dbus_read || dbus_write) && dbus_stall;
	prev_d_read  = dbus_read;
	prev_d_write = dbus_write;
	prev_iaddr   = ibus_address;
	prev_daddr   = dbus_address;
	prev_wdata   = dbus_wdata;
endtask

initial begin
	clk          = 1'b0;
	rst_n        = 1'b0;
	ibus_rddata  = '0;
	ibus_stall   = 1'b0;
	dbus_rddata  = '0;
	dbus_stall   = 1'b0;
	seed         = 32'd27313;
	errors       = 0;
	st_idx       = 0;
	ld_idx       = 0;
	end_fetches  = 0;
	first_cycle  = 1'b1;
	prev_i_wait  = 1'b0;
	prev_d_wait  = 1'b0;
	prev_d_read  = 1'b0;
	prev_d_write = 1'b0;
	prev_iaddr   = '0;
	prev_daddr   = '0;
	prev_wdata   = '0;
	gen_program();
	run_iss();
	for (int i = 0; i < 64; i++) begin
		dmem[i] = fill_word(i);
	end
	for (int i = 0; i < 16; i++) begin
		@(posedge clk);
		#1;
		drive_inputs();
	end
	rst_n = 1'b1;
	// run until the final branch has spun long enough
	for (cycles = 0; cycles < MAX_CYCLES && end_fetches < END_FETCHES; cycles++) begin
		@(negedge clk);
		monitor_cycle();
		@(posedge clk);
		#1;
		drive_inputs();
	end
	assert (end_fetches >= END_FETCHES) else begin
		errors++;
		$display("timeout after %0d cycles, program end not reached", MAX_CYCLES);
	end
	assert (st_idx == exp_st_addr.size()) else begin
		errors++;
		$display("wrong number of stores, %0d seen and %0d expected",
			st_idx, exp_st_addr.size());
	end
	assert (ld_idx == exp_ld_addr.size()) else begin
		errors++;
		$display("wrong number of loads, %0d seen and %0d expected",
			ld_idx, exp_ld_addr.size());
	end
	$display("stores %0d of %0d, loads %0d of %0d, errors %0d",
		st_idx, exp_st_addr.size(), ld_idx, exp_ld_addr.size(), errors);
	if (errors == 0) begin
		$display("TEST OK");
	end else begin
		$display("TEST FAILED");
	end
	$finish;
end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_fetch.sv
rtl/decode_issue.sv
rtl/regfile.sv
rtl/instr_exec.sv
rtl/instr_mem.sv
rtl/ctrl.sv
rtl/cpu_core.sv
tests/cpu_core_chk.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module cpu_core_tb -o cpu_core_sim

./obj_dir/cpu_core_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1
